//--- flist.f
+incdir+source
source/lsu_pkg.sv
source/l1d_rd_if.sv
source/lsu_dcache.sv
source/lsu_miss_unit.sv
source/lsu_load_pipe.sv
source/lsu_side_ports.sv
source/lsu_ctrl_regs.sv
source/lsu_top.sv
tests/tb_lsu_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_lsu_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Test passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- tests/tb_lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defines.svh"

module tb_lsu_top;

  localparam int CLK_PERIOD = 40;
  localparam int NUM_OPS    = 3000;
  // Worst miss in cycles over request, ready delay, response delay and refill
  localparam int MISS_WORST = 16;
  localparam int WATCHDOG_CYCLES = 20 + NUM_OPS * MISS_WORST;
  localparam int NUM_LINES  = 1 << `LSU_INDEX_W;
  localparam int OFF_W      = $clog2(`LSU_LINE_W / 8);
  localparam int TAG_W      = `LSU_PADDR_W - `LSU_INDEX_W - OFF_W;
  localparam logic [31:0] MEM_XOR = 32'h5a5a_c3c3;

  // Refilled means the line was written on the last rising edge
  typedef enum int {L2_IDLE, L2_REQ, L2_WAIT, L2_DONE, L2_REFILLED} l2_state_t;

  logic                       clk;
  logic                       reset_n;
  logic                       ld_valid;
  logic [`LSU_PADDR_W-1:0]    ld_paddr;
  logic                       ld_resp_valid;
  lsu_pkg::l1d_status_t       ld_resp_status;
  logic [`LSU_XLEN_W-1:0]     ld_resp_data;
  logic                       ptw_req_valid;
  logic [`LSU_PADDR_W-1:0]    ptw_paddr;
  logic                       ptw_resp_valid;
  lsu_pkg::l1d_status_t       ptw_resp_status;
  logic [`LSU_XLEN_W-1:0]     ptw_resp_data;
  logic                       snoop_req_valid;
  logic [`LSU_PADDR_W-1:0]    snoop_paddr;
  logic                       snoop_resp_valid;
  lsu_pkg::l1d_status_t       snoop_resp_status;
  logic [`LSU_LINE_W/8-1:0]   snoop_resp_be;
  logic [`LSU_LINE_W-1:0]     snoop_resp_data;
  logic                       l2_req_valid;
  logic [`LSU_PADDR_W-1:0]    l2_req_paddr;
  logic                       l2_req_ready;
  logic                       l2_resp_valid;
  logic [`LSU_LINE_W-1:0]     l2_resp_data;
  logic                       miss_busy;
  logic                       cfg_wr;
  logic [1:0]                 cfg_addr;
  logic [31:0]                cfg_wdata;
  logic [31:0]                cfg_rdata;

  // Cache model with one entry per index
  logic                       mdl_valid [NUM_LINES];
  logic [TAG_W-1:0]           mdl_tag   [NUM_LINES];

  // Requests sampled at the last rising edge
  logic                       prev_ld_valid;
  logic                       prev_ptw_valid;
  logic                       prev_snoop_valid;
  logic [`LSU_PADDR_W-1:0]    prev_ld_paddr;
  logic [`LSU_PADDR_W-1:0]    prev_ptw_paddr;
  logic [`LSU_PADDR_W-1:0]    prev_snoop_paddr;
  logic                       refill_now;
  logic [1:0]                 inval_pipe;
  logic                       expect_req;
  logic [`LSU_PADDR_W-1:0]    expect_req_addr;
  logic [`LSU_PADDR_W-1:0]    l2_line_addr;
  l2_state_t                  l2_state;
  int                         ready_delay;
  int                         resp_delay;
  int                         hit_tally;
  int                         miss_tally;
  int                         refill_tally;

  lsu_top DUT (
    .i_clk               (clk),
    .i_reset_n           (reset_n),
    .i_ld_valid          (ld_valid),
    .i_ld_paddr          (ld_paddr),
    .o_ld_resp_valid     (ld_resp_valid),
    .o_ld_resp_status    (ld_resp_status),
    .o_ld_resp_data      (ld_resp_data),
    .i_ptw_req_valid     (ptw_req_valid),
    .i_ptw_paddr         (ptw_paddr),
    .o_ptw_resp_valid    (ptw_resp_valid),
    .o_ptw_resp_status   (ptw_resp_status),
    .o_ptw_resp_data     (ptw_resp_data),
    .i_snoop_req_valid   (snoop_req_valid),
    .i_snoop_paddr       (snoop_paddr),
    .o_snoop_resp_valid  (snoop_resp_valid),
    .o_snoop_resp_status (snoop_resp_status),
    .o_snoop_resp_be     (snoop_resp_be),
    .o_snoop_resp_data   (snoop_resp_data),
    .o_l2_req_valid      (l2_req_valid),
    .o_l2_req_paddr      (l2_req_paddr),
    .i_l2_req_ready      (l2_req_ready),
    .i_l2_resp_valid     (l2_resp_valid),
    .i_l2_resp_data      (l2_resp_data),
    .o_miss_busy         (miss_busy),
    .i_cfg_wr            (cfg_wr),
    .i_cfg_addr          (cfg_addr),
    .i_cfg_wdata         (cfg_wdata),
    .o_cfg_rdata         (cfg_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Test failed");
    $fatal(1, "Watchdog expired");
  end

  task automatic check(input string name, input logic [127:0] actual,
                       input logic [127:0] expected);
    if (actual !== expected) begin
      $display("ERROR t=%0t %s: got %0h, expected %0h", $time, name, actual, expected);
      $display("Test failed");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  // ------------------------------------------------------------
  // Memory contents and address generation
  // ------------------------------------------------------------
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return {addr[31:2], 2'b00} ^ MEM_XOR;
  endfunction

  function automatic logic [127:0] mem_line(input logic [31:0] addr);
    logic [127:0] line;
    for (int i = 0; i < 4; i++) begin
      line[i*32 +: 32] = mem_word({addr[31:4], 4'h0} + 32'(i * 4));
    end
    return line;
  endfunction

  // 4 tags over 4 indices so that lines alias
  function automatic logic [31:0] rand_addr();
    logic [1:0]              tsel;
    logic [1:0]              isel;
    logic [1:0]              wsel;
    logic [TAG_W-1:0]        tag;
    logic [`LSU_INDEX_W-1:0] index;
    tsel  = 2'($urandom);
    isel  = 2'($urandom);
    wsel  = 2'($urandom);
    tag   = 22'h001b3 + 22'(tsel) * 22'h0d417;
    index = 6'h05 + 6'(isel) * 6'h0e;
    return {tag, index, wsel, 2'b00};
  endfunction

  function automatic lsu_pkg::l1d_status_t expect_status(input logic [31:0] addr);
    logic [`LSU_INDEX_W-1:0] index;
    index = addr[OFF_W +: `LSU_INDEX_W];
    if (refill_now && index == l2_line_addr[OFF_W +: `LSU_INDEX_W]) begin
      return lsu_pkg::STATUS_CONFLICT;
    end
    if (mdl_valid[index] && mdl_tag[index] == addr[`LSU_PADDR_W-1 -: TAG_W]) begin
      return lsu_pkg::STATUS_HIT;
    end
    return lsu_pkg::STATUS_MISS;
  endfunction

  // ------------------------------------------------------------
  // Per-cycle model update and checks
  // ------------------------------------------------------------
  task automatic update_model();
    logic busy_exp;
    // Busy from the cycle after the miss through the refill write
    busy_exp = expect_req || l2_state == L2_REQ || l2_state == L2_WAIT ||
               l2_state == L2_DONE;
    check("o_miss_busy", 128'(miss_busy), 128'(busy_exp));
    refill_now = (l2_state == L2_REFILLED);
    // Invalidate lands first and a refill on the same edge survives
    if (inval_pipe[1]) begin
      for (int i = 0; i < NUM_LINES; i++) begin
        mdl_valid[i] = 1'b0;
      end
    end
    if (refill_now) begin
      mdl_valid[l2_line_addr[OFF_W +: `LSU_INDEX_W]] = 1'b1;
      mdl_tag[l2_line_addr[OFF_W +: `LSU_INDEX_W]]   = l2_line_addr[`LSU_PADDR_W-1 -: TAG_W];
      refill_tally++;
      l2_state = L2_IDLE;
    end else if (l2_state == L2_DONE) begin
      l2_state = L2_REFILLED;
    end
  endtask

  task automatic check_l2_request();
    if (expect_req) begin
      check("o_l2_req_valid", 128'(l2_req_valid), 128'(1'b1));
      check("o_l2_req_paddr", 128'(l2_req_paddr), 128'(expect_req_addr));
      expect_req   = 1'b0;
      l2_line_addr = expect_req_addr;
      ready_delay  = $urandom_range(0, 3);
      l2_state     = L2_REQ;
    end else if (l2_state == L2_REQ) begin
      check("o_l2_req_valid", 128'(l2_req_valid), 128'(1'b1));
      check("o_l2_req_paddr", 128'(l2_req_paddr), 128'(l2_line_addr));
    end else begin
      check("o_l2_req_valid", 128'(l2_req_valid), 128'(1'b0));
    end
  endtask

  task automatic check_responses();
    lsu_pkg::l1d_status_t exp;
    check("o_ld_resp_valid", 128'(ld_resp_valid), 128'(prev_ld_valid));
    check("o_ptw_resp_valid", 128'(ptw_resp_valid), 128'(prev_ptw_valid));
    check("o_snoop_resp_valid", 128'(snoop_resp_valid), 128'(prev_snoop_valid));
    if (prev_ld_valid) begin
      exp = expect_status(prev_ld_paddr);
      check("o_ld_resp_status", 128'(ld_resp_status), 128'(exp));
      check("o_ld_resp_data", 128'(ld_resp_data),
            128'(exp == lsu_pkg::STATUS_HIT ? mem_word(prev_ld_paddr) : 32'h0));
      if (exp == lsu_pkg::STATUS_HIT) begin
        hit_tally++;
      end
      if (exp == lsu_pkg::STATUS_MISS) begin
        miss_tally++;
        // Idle miss unit takes the line
        if (l2_state == L2_IDLE) begin
          expect_req      = 1'b1;
          expect_req_addr = {prev_ld_paddr[31:OFF_W], {OFF_W{1'b0}}};
        end
      end
    end
    if (prev_ptw_valid) begin
      exp = expect_status(prev_ptw_paddr);
      check("o_ptw_resp_status", 128'(ptw_resp_status), 128'(exp));
      check("o_ptw_resp_data", 128'(ptw_resp_data),
            128'(exp == lsu_pkg::STATUS_HIT ? mem_word(prev_ptw_paddr) : 32'h0));
    end
    if (prev_snoop_valid) begin
      exp = expect_status(prev_snoop_paddr);
      check("o_snoop_resp_status", 128'(snoop_resp_status), 128'(exp));
      check("o_snoop_resp_be", 128'(snoop_resp_be),
            128'(exp == lsu_pkg::STATUS_HIT ? 16'hffff : 16'h0));
      check("o_snoop_resp_data", 128'(snoop_resp_data),
            exp == lsu_pkg::STATUS_HIT ? mem_line(prev_snoop_paddr) : 128'h0);
    end
  endtask

  // L2 model gives ready after 0 to 3 cycles and a response 2 to 8 cycles later
  task automatic drive_l2();
    l2_req_ready  = 1'b0;
    l2_resp_valid = 1'b0;
    l2_resp_data  = '0;
    if (l2_state == L2_REQ) begin
      if (ready_delay == 0) begin
        l2_req_ready = 1'b1;
        resp_delay   = $urandom_range(2, 8);
        l2_state     = L2_WAIT;
      end else begin
        ready_delay--;
      end
    end else if (l2_state == L2_WAIT) begin
      resp_delay--;
      if (resp_delay == 0) begin
        l2_resp_valid = 1'b1;
        l2_resp_data  = mem_line(l2_line_addr);
        l2_state      = L2_DONE;
      end
    end
  endtask

  task automatic drive_requests(input bit traffic);
    ld_valid         = traffic && ($urandom_range(0, 3) != 0);
    ld_paddr         = rand_addr();
    ptw_req_valid    = traffic && ($urandom_range(0, 3) == 0);
    ptw_paddr        = rand_addr();
    snoop_req_valid  = traffic && ($urandom_range(0, 3) == 0);
    snoop_paddr      = rand_addr();
    cfg_wr           = traffic && ($urandom_range(0, 99) == 0);
    cfg_addr         = 2'd0;
    cfg_wdata        = 32'h1;
    inval_pipe       = {inval_pipe[0], cfg_wr};
    prev_ld_valid    = ld_valid;
    prev_ld_paddr    = ld_paddr;
    prev_ptw_valid   = ptw_req_valid;
    prev_ptw_paddr   = ptw_paddr;
    prev_snoop_valid = snoop_req_valid;
    prev_snoop_paddr = snoop_paddr;
  endtask

  task automatic step(input bit traffic);
    @(negedge clk);
    update_model();
    check_l2_request();
    check_responses();
    drive_l2();
    drive_requests(traffic);
  endtask

  task automatic read_cfg(input logic [1:0] addr, input int expected, input string name);
    cfg_addr = addr;
    @(negedge clk);
    check(name, 128'(cfg_rdata), 128'(expected));
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    void'($urandom(32'h79cb_9810));
    reset_n = 1'b0;
    drive_requests(1'b0);
    drive_l2();
    refill_now   = 1'b0;
    inval_pipe   = 2'b00;
    expect_req   = 1'b0;
    l2_line_addr = '0;
    l2_state     = L2_IDLE;
    hit_tally    = 0;
    miss_tally   = 0;
    refill_tally = 0;
    for (int i = 0; i < NUM_LINES; i++) begin
      mdl_valid[i] = 1'b0;
      mdl_tag[i]   = '0;
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    check("o_ld_resp_valid", 128'(ld_resp_valid), 128'(1'b0));
    check("o_ptw_resp_valid", 128'(ptw_resp_valid), 128'(1'b0));
    check("o_snoop_resp_valid", 128'(snoop_resp_valid), 128'(1'b0));
    check("o_l2_req_valid", 128'(l2_req_valid), 128'(1'b0));
    check("o_miss_busy", 128'(miss_busy), 128'(1'b0));
    reset_n = 1'b1;

    for (int n = 0; n < NUM_OPS; n++) begin
      step(1'b1);
    end
    // Drain the last miss and invalidate
    do begin
      step(1'b0);
    end while (l2_state != L2_IDLE || expect_req || miss_busy || inval_pipe != 2'b00);

    read_cfg(2'd0, 0, "o_cfg_rdata addr 0");
    read_cfg(2'd1, hit_tally, "hit counter");
    read_cfg(2'd2, miss_tally, "miss counter");
    read_cfg(2'd3, refill_tally, "refill counter");
    $display("Loads hit %0d, missed %0d, refills %0d", hit_tally, miss_tally, refill_tally);

    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- source/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defines.svh"

module lsu_top (
  input  wire logic                     i_clk,
  input  wire logic                     i_reset_n,

  // Load pipe
  input  wire logic                     i_ld_valid,
  input  wire logic [`LSU_PADDR_W-1:0]  i_ld_paddr,
  output logic                          o_ld_resp_valid,
  output lsu_pkg::l1d_status_t          o_ld_resp_status,
  output logic [`LSU_XLEN_W-1:0]        o_ld_resp_data,

  // PTW access
  input  wire logic                     i_ptw_req_valid,
  input  wire logic [`LSU_PADDR_W-1:0]  i_ptw_paddr,
  output logic                          o_ptw_resp_valid,
  output lsu_pkg::l1d_status_t          o_ptw_resp_status,
  output logic [`LSU_XLEN_W-1:0]        o_ptw_resp_data,

  // Snoop access
  input  wire logic                     i_snoop_req_valid,
  input  wire logic [`LSU_PADDR_W-1:0]  i_snoop_paddr,
  output logic                          o_snoop_resp_valid,
  output lsu_pkg::l1d_status_t          o_snoop_resp_status,
  output logic [`LSU_LINE_W/8-1:0]      o_snoop_resp_be,
  output logic [`LSU_LINE_W-1:0]        o_snoop_resp_data,

  // L2 read channel
  output logic                          o_l2_req_valid,
  output logic [`LSU_PADDR_W-1:0]       o_l2_req_paddr,
  input  wire logic                     i_l2_req_ready,
  input  wire logic                     i_l2_resp_valid,
  input  wire logic [`LSU_LINE_W-1:0]   i_l2_resp_data,

  output logic                          o_miss_busy,

  // Configuration
  input  wire logic                     i_cfg_wr,
  input  wire logic [1:0]               i_cfg_addr,
  input  wire logic [31:0]              i_cfg_wdata,
  output logic [31:0]                   o_cfg_rdata
);

  l1d_rd_if w_rd [`LSU_RD_PORT_NUM] ();

  logic                    w_miss_req;
  logic [`LSU_PADDR_W-1:0] w_miss_paddr;
  logic                    w_refill_valid;
  logic [`LSU_PADDR_W-1:0] w_refill_paddr;
  logic [`LSU_LINE_W-1:0]  w_refill_data;
  logic                    w_inval;
  logic                    w_hit_evt;
  logic                    w_miss_evt;
  logic                    w_refill_evt;

  lsu_dcache #(
    .RD_PORT_NUM (`LSU_RD_PORT_NUM)
  ) u_dcache (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .rd             (w_rd),
    .i_refill_valid (w_refill_valid),
    .i_refill_paddr (w_refill_paddr),
    .i_refill_data  (w_refill_data),
    .i_inval        (w_inval)
  );

  lsu_load_pipe u_load_pipe (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_ld_valid       (i_ld_valid),
    .i_ld_paddr       (i_ld_paddr),
    .rd               (w_rd[`LSU_LD_PORT]),
    .i_miss_busy      (o_miss_busy),
    .o_miss_req       (w_miss_req),
    .o_miss_paddr     (w_miss_paddr),
    .o_ld_resp_valid  (o_ld_resp_valid),
    .o_ld_resp_status (o_ld_resp_status),
    .o_ld_resp_data   (o_ld_resp_data),
    .o_hit_evt        (w_hit_evt),
    .o_miss_evt       (w_miss_evt)
  );

  lsu_side_ports u_side_ports (
    .i_clk               (i_clk),
    .i_reset_n           (i_reset_n),
    .ptw_rd              (w_rd[`LSU_PTW_PORT]),
    .snoop_rd            (w_rd[`LSU_SNOOP_PORT]),
    .i_ptw_req_valid     (i_ptw_req_valid),
    .i_ptw_paddr         (i_ptw_paddr),
    .o_ptw_resp_valid    (o_ptw_resp_valid),
    .o_ptw_resp_status   (o_ptw_resp_status),
    .o_ptw_resp_data     (o_ptw_resp_data),
    .i_snoop_req_valid   (i_snoop_req_valid),
    .i_snoop_paddr       (i_snoop_paddr),
    .o_snoop_resp_valid  (o_snoop_resp_valid),
    .o_snoop_resp_status (o_snoop_resp_status),
    .o_snoop_resp_be     (o_snoop_resp_be),
    .o_snoop_resp_data   (o_snoop_resp_data)
  );

  lsu_miss_unit u_miss_unit (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_miss_req      (w_miss_req),
    .i_miss_paddr    (w_miss_paddr),
    .o_miss_busy     (o_miss_busy),
    .o_l2_req_valid  (o_l2_req_valid),
    .o_l2_req_paddr  (o_l2_req_paddr),
    .i_l2_req_ready  (i_l2_req_ready),
    .i_l2_resp_valid (i_l2_resp_valid),
    .i_l2_resp_data  (i_l2_resp_data),
    .o_refill_valid  (w_refill_valid),
    .o_refill_paddr  (w_refill_paddr),
    .o_refill_data   (w_refill_data),
    .o_refill_evt    (w_refill_evt)
  );

  lsu_ctrl_regs u_ctrl_regs (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_cfg_wr     (i_cfg_wr),
    .i_cfg_addr   (i_cfg_addr),
    .i_cfg_wdata  (i_cfg_wdata),
    .o_cfg_rdata  (o_cfg_rdata),
    .o_inval      (w_inval),
    .i_hit_evt    (w_hit_evt),
    .i_miss_evt   (w_miss_evt),
    .i_refill_evt (w_refill_evt)
  );

endmodule

`default_nettype wire

//--- source/lsu_ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_ctrl_regs (
  input  wire logic        i_clk,
  input  wire logic        i_reset_n,

  input  wire logic        i_cfg_wr,
  input  wire logic [1:0]  i_cfg_addr,
  input  wire logic [31:0] i_cfg_wdata,
  output logic [31:0]      o_cfg_rdata,

  output logic             o_inval,

  input  wire logic        i_hit_evt,
  input  wire logic        i_miss_evt,
  input  wire logic        i_refill_evt
);

  logic            r_inval;
  logic [2:0][15:0] r_cnt;
  logic [2:0]       w_evt;

  // Counter slot n sits at address n+1
  assign w_evt = {i_refill_evt, i_miss_evt, i_hit_evt};

  // ------------------------------------------------------------
  // Invalidate command
  // ------------------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_inval <= 1'b0;
    end else begin
      r_inval <= i_cfg_wr & (i_cfg_addr == 2'd0) & i_cfg_wdata[0];
    end
  end

  assign o_inval = r_inval;

  // Saturating event counters
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_cnt <= '0;
    end else begin
      for (int i = 0; i < 3; i++) begin
        if (w_evt[i] && r_cnt[i] != 16'hffff) begin
          r_cnt[i] <= r_cnt[i] + 16'd1;
        end
      end
    end
  end

  always_comb begin
    case (i_cfg_addr)
      2'd1:    o_cfg_rdata = {16'h0, r_cnt[0]};
      2'd2:    o_cfg_rdata = {16'h0, r_cnt[1]};
      2'd3:    o_cfg_rdata = {16'h0, r_cnt[2]};
      default: o_cfg_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- source/lsu_side_ports.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defines.svh"

module lsu_side_ports (
  input  wire logic                      i_clk,
  input  wire logic                      i_reset_n,

  l1d_rd_if.requester                    ptw_rd,
  l1d_rd_if.requester                    snoop_rd,

  input  wire logic                      i_ptw_req_valid,
  input  wire logic [`LSU_PADDR_W-1:0]   i_ptw_paddr,
  output logic                           o_ptw_resp_valid,
  output lsu_pkg::l1d_status_t           o_ptw_resp_status,
  output logic [`LSU_XLEN_W-1:0]         o_ptw_resp_data,

  input  wire logic                      i_snoop_req_valid,
  input  wire logic [`LSU_PADDR_W-1:0]   i_snoop_paddr,
  output logic                           o_snoop_resp_valid,
  output lsu_pkg::l1d_status_t           o_snoop_resp_status,
  output logic [`LSU_LINE_W/8-1:0]       o_snoop_resp_be,
  output lsu_pkg::line_t                 o_snoop_resp_data
);

  localparam int BYTE_W = $clog2(`LSU_XLEN_W / 8);
  localparam int SEL_W  = $clog2(`LSU_LINE_W / `LSU_XLEN_W);

  logic             r_ptw_resp_valid;
  logic             r_snoop_resp_valid;
  logic [SEL_W-1:0] r_ptw_word_sel;

  function automatic lsu_pkg::l1d_status_t to_status(input logic hit, input logic miss,
                                                     input logic conflict);
    if (conflict) return lsu_pkg::STATUS_CONFLICT;
    if (hit) return lsu_pkg::STATUS_HIT;
    if (miss) return lsu_pkg::STATUS_MISS;
    return lsu_pkg::STATUS_NONE;
  endfunction

  assign ptw_rd.s0_valid   = i_ptw_req_valid;
  assign ptw_rd.s0_paddr   = i_ptw_paddr;
  assign snoop_rd.s0_valid = i_snoop_req_valid;
  assign snoop_rd.s0_paddr = i_snoop_paddr;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ptw_resp_valid   <= 1'b0;
      r_snoop_resp_valid <= 1'b0;
    end else begin
      r_ptw_resp_valid   <= i_ptw_req_valid;
      r_snoop_resp_valid <= i_snoop_req_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ptw_word_sel <= i_ptw_paddr[BYTE_W +: SEL_W];
  end

  // ------------------------------------------------------------
  // PTW returns one word
  // ------------------------------------------------------------
  assign o_ptw_resp_valid  = r_ptw_resp_valid;
  assign o_ptw_resp_status = to_status(ptw_rd.s1_hit, ptw_rd.s1_miss, ptw_rd.s1_conflict);
  assign o_ptw_resp_data   = ptw_rd.s1_data[r_ptw_word_sel * `LSU_XLEN_W +: `LSU_XLEN_W];

  // ------------------------------------------------------------
  // Snoop returns the whole line
  // ------------------------------------------------------------
  assign o_snoop_resp_valid  = r_snoop_resp_valid;
  assign o_snoop_resp_status = to_status(snoop_rd.s1_hit, snoop_rd.s1_miss,
                                         snoop_rd.s1_conflict);
  assign o_snoop_resp_be     = snoop_rd.s1_hit ? '1 : '0;
  assign o_snoop_resp_data   = snoop_rd.s1_data;

endmodule

`default_nettype wire

//--- source/lsu_load_pipe.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defines.svh"

module lsu_load_pipe (
  input  wire logic                    i_clk,
  input  wire logic                    i_reset_n,

  input  wire logic                    i_ld_valid,
  input  wire logic [`LSU_PADDR_W-1:0] i_ld_paddr,

  l1d_rd_if.requester                  rd,

  input  wire logic                    i_miss_busy,
  output logic                         o_miss_req,
  output logic [`LSU_PADDR_W-1:0]      o_miss_paddr,

  output logic                         o_ld_resp_valid,
  output lsu_pkg::l1d_status_t         o_ld_resp_status,
  output logic [`LSU_XLEN_W-1:0]       o_ld_resp_data,

  output logic                         o_hit_evt,
  output logic                         o_miss_evt
);

  localparam int BYTE_W = $clog2(`LSU_XLEN_W / 8);
  localparam int SEL_W  = $clog2(`LSU_LINE_W / `LSU_XLEN_W);

  logic                    r_s1_valid;
  logic [`LSU_PADDR_W-1:0] r_s1_paddr;
  logic [SEL_W-1:0]        w_word_sel;

  assign rd.s0_valid = i_ld_valid;
  assign rd.s0_paddr = i_ld_paddr;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_valid <= 1'b0;
    end else begin
      r_s1_valid <= i_ld_valid;
    end
  end

  // Kept for the word select and the miss address
  always_ff @(posedge i_clk) begin
    r_s1_paddr <= i_ld_paddr;
  end

  assign w_word_sel = r_s1_paddr[BYTE_W +: SEL_W];

  // ------------------------------------------------------------
  // Response and miss hand-off
  // ------------------------------------------------------------
  assign o_ld_resp_valid  = r_s1_valid;
  assign o_ld_resp_status = rd.s1_conflict ? lsu_pkg::STATUS_CONFLICT :
                            rd.s1_hit      ? lsu_pkg::STATUS_HIT :
                            rd.s1_miss     ? lsu_pkg::STATUS_MISS :
                                             lsu_pkg::STATUS_NONE;
  assign o_ld_resp_data   = rd.s1_hit ? rd.s1_data[w_word_sel * `LSU_XLEN_W +: `LSU_XLEN_W] :
                                        '0;

  // Dropped while the single miss entry is taken
  assign o_miss_req   = r_s1_valid & rd.s1_miss & ~i_miss_busy;
  assign o_miss_paddr = r_s1_paddr;

  assign o_hit_evt  = r_s1_valid & rd.s1_hit;
  assign o_miss_evt = r_s1_valid & rd.s1_miss;

endmodule

`default_nettype wire

//--- source/lsu_miss_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defines.svh"

module lsu_miss_unit (
  input  wire logic                    i_clk,
  input  wire logic                    i_reset_n,

  input  wire logic                    i_miss_req,
  input  wire logic [`LSU_PADDR_W-1:0] i_miss_paddr,
  output logic                         o_miss_busy,

  output logic                         o_l2_req_valid,
  output logic [`LSU_PADDR_W-1:0]      o_l2_req_paddr,
  input  wire logic                    i_l2_req_ready,
  input  wire logic                    i_l2_resp_valid,
  input  lsu_pkg::line_t               i_l2_resp_data,

  output logic                         o_refill_valid,
  output logic [`LSU_PADDR_W-1:0]      o_refill_paddr,
  output lsu_pkg::line_t               o_refill_data,
  output logic                         o_refill_evt
);

  localparam int OFF_W = $clog2(`LSU_LINE_W / 8);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_WAIT,
    ST_REFILL
  } miss_state_t;

  miss_state_t r_state;

  logic [`LSU_PADDR_W-OFF_W-1:0] r_line_addr;
  lsu_pkg::line_t                r_line_data;

  // ------------------------------------------------------------
  // Single entry FSM
  // ------------------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= ST_IDLE;
    end else begin
      case (r_state)
        ST_IDLE:   if (i_miss_req) r_state <= ST_REQ;
        ST_REQ:    if (i_l2_req_ready) r_state <= ST_WAIT;
        ST_WAIT:   if (i_l2_resp_valid) r_state <= ST_REFILL;
        ST_REFILL: r_state <= ST_IDLE;
        default:   r_state <= ST_IDLE;
      endcase
    end
  end

  // Line address and returned data
  always_ff @(posedge i_clk) begin
    if (r_state == ST_IDLE && i_miss_req) begin
      r_line_addr <= i_miss_paddr[`LSU_PADDR_W-1:OFF_W];
    end
    if (r_state == ST_WAIT && i_l2_resp_valid) begin
      r_line_data <= i_l2_resp_data;
    end
  end

  assign o_miss_busy    = (r_state != ST_IDLE);
  assign o_l2_req_valid = (r_state == ST_REQ);
  assign o_l2_req_paddr = {r_line_addr, {OFF_W{1'b0}}};

  assign o_refill_valid = (r_state == ST_REFILL);
  assign o_refill_paddr = {r_line_addr, {OFF_W{1'b0}}};
  assign o_refill_data  = r_line_data;
  assign o_refill_evt   = o_refill_valid;

  // L2 request holds its address until accepted
  a_req_stable : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    o_l2_req_valid && !i_l2_req_ready |=> o_l2_req_valid && $stable(o_l2_req_paddr)
  );

endmodule

`default_nettype wire

//--- source/lsu_dcache.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defines.svh"

module lsu_dcache #(
  parameter int RD_PORT_NUM = `LSU_RD_PORT_NUM
) (
  input  wire logic                    i_clk,
  input  wire logic                    i_reset_n,

  l1d_rd_if.cache                      rd [RD_PORT_NUM],

  input  wire logic                    i_refill_valid,
  input  wire logic [`LSU_PADDR_W-1:0] i_refill_paddr,
  input  lsu_pkg::line_t               i_refill_data,
  input  wire logic                    i_inval
);

  localparam int NUM_LINES = 1 << `LSU_INDEX_W;
  localparam int OFF_W     = $clog2(`LSU_LINE_W / 8);
  localparam int TAG_W     = `LSU_PADDR_W - `LSU_INDEX_W - OFF_W;

  logic [NUM_LINES-1:0] r_valid;
  logic [TAG_W-1:0]     r_tag  [NUM_LINES];
  lsu_pkg::line_t       r_data [NUM_LINES];

  logic [`LSU_INDEX_W-1:0] w_refill_index;
  logic [TAG_W-1:0]        w_refill_tag;

  assign w_refill_index = i_refill_paddr[OFF_W +: `LSU_INDEX_W];
  assign w_refill_tag   = i_refill_paddr[`LSU_PADDR_W-1 -: TAG_W];

  // ------------------------------------------------------------
  // Array update
  // ------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_refill_valid) begin
      r_tag[w_refill_index]  <= w_refill_tag;
      r_data[w_refill_index] <= i_refill_data;
    end
  end

  // A refill in the same cycle as invalidate keeps its line
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= '0;
    end else begin
      if (i_inval) begin
        r_valid <= '0;
      end
      if (i_refill_valid) begin
        r_valid[w_refill_index] <= 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // Read ports served in parallel
  // ------------------------------------------------------------
  for (genvar gi = 0; gi < RD_PORT_NUM; gi++) begin : g_port
    logic                    r_s1_valid;
    logic                    r_s1_conflict;
    logic [`LSU_PADDR_W-1:0] r_s1_paddr;
    logic [`LSU_INDEX_W-1:0] w_s1_index;
    logic                    w_s1_hit;

    always_ff @(posedge i_clk, negedge i_reset_n) begin
      if (!i_reset_n) begin
        r_s1_valid    <= 1'b0;
        r_s1_conflict <= 1'b0;
      end else begin
        r_s1_valid    <= rd[gi].s0_valid;
        // Refill to the same index lands under this lookup
        r_s1_conflict <= rd[gi].s0_valid & i_refill_valid &
                         (rd[gi].s0_paddr[OFF_W +: `LSU_INDEX_W] == w_refill_index);
      end
    end

    always_ff @(posedge i_clk) begin
      r_s1_paddr <= rd[gi].s0_paddr;
    end

    assign w_s1_index = r_s1_paddr[OFF_W +: `LSU_INDEX_W];
    assign w_s1_hit   = r_s1_valid & ~r_s1_conflict & r_valid[w_s1_index] &
                        (r_tag[w_s1_index] == r_s1_paddr[`LSU_PADDR_W-1 -: TAG_W]);

    assign rd[gi].s1_hit      = w_s1_hit;
    assign rd[gi].s1_miss     = r_s1_valid & ~r_s1_conflict & ~w_s1_hit;
    assign rd[gi].s1_conflict = r_s1_valid & r_s1_conflict;
    assign rd[gi].s1_data     = w_s1_hit ? r_data[w_s1_index] : '0;

    // Each request gets exactly one answer in the following cycle
    a_one_answer : assert property (
      @(posedge i_clk) disable iff (!i_reset_n)
      rd[gi].s0_valid |=> $onehot({rd[gi].s1_hit, rd[gi].s1_miss, rd[gi].s1_conflict})
    );
  end

endmodule

`default_nettype wire

//--- source/l1d_rd_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defines.svh"

interface l1d_rd_if;

  // Stage s0, request
  logic                    s0_valid;
  logic [`LSU_PADDR_W-1:0] s0_paddr;

  // Stage s1, exactly one flag per request
  logic                    s1_hit;
  logic                    s1_miss;
  logic                    s1_conflict;
  lsu_pkg::line_t          s1_data;

  modport requester (
    output s0_valid, s0_paddr,
    input  s1_hit, s1_miss, s1_conflict, s1_data
  );

  modport cache (
    input  s0_valid, s0_paddr,
    output s1_hit, s1_miss, s1_conflict, s1_data
  );

endinterface

`default_nettype wire

//--- source/lsu_pkg.sv
`default_nettype none

`include "lsu_defines.svh"

package lsu_pkg;

  // Result of one cache lookup as seen by a requester
  typedef enum logic [1:0] {
    STATUS_NONE,
    STATUS_HIT,
    STATUS_MISS,
    STATUS_CONFLICT
  } l1d_status_t;

  // One full cache line
  typedef logic [`LSU_LINE_W-1:0] line_t;

endpackage

`default_nettype wire

//--- source/lsu_defines.svh
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// ------------------------------------------------------------
// Address and data widths
// ------------------------------------------------------------
`define LSU_PADDR_W 32
`define LSU_XLEN_W 32

// Four words per line
`define LSU_LINE_W 128

// 64 lines, direct mapped
`define LSU_INDEX_W 6

// ------------------------------------------------------------
// Cache read port numbering
// ------------------------------------------------------------
`define LSU_SNOOP_PORT 0
`define LSU_PTW_PORT 1
`define LSU_LD_PORT 2
`define LSU_RD_PORT_NUM 3

`endif
